/* chan_emu_pkg.sv */
package chan_emu_pkg;

    localparam int CHUNK_WIDTH     = 8;                  // bits per history chunk
    localparam int NUM_CHUNKS      = 4;                  // chunks summed per frame
    localparam int NUM_SLICES      = 8;                  // lanes, also new bits per frame
    localparam int FRAME_CYCLES    = NUM_CHUNKS + 2;
    localparam int CNT_WIDTH       = $clog2(FRAME_CYCLES);
    localparam int CHUNK_IDX_WIDTH = $clog2(NUM_CHUNKS);
    localparam int SLICE_IDX_WIDTH = $clog2(NUM_SLICES);

    // clk_adc is low from CLK_FALL to CLK_RISE, giving 50% duty over a frame
    localparam int CLK_FALL = 2;
    localparam int CLK_RISE = CLK_FALL + (2 + NUM_CHUNKS) / 2 - 1;

    localparam int WINDOW_WIDTH = CHUNK_WIDTH + NUM_SLICES - 1;
    localparam int HIST_WIDTH   = NUM_CHUNKS * CHUNK_WIDTH + NUM_SLICES - 1;
    localparam int TABLE_DEPTH  = 2 ** CHUNK_WIDTH;      // one entry per chunk value

    localparam int COEF_WIDTH      = 16;
    localparam int ADC_WIDTH       = 8;
    localparam int ACC_WIDTH       = 20;
    localparam int NOISE_WIDTH     = 8;
    localparam int NOISE_LVL_WIDTH = 4;

    localparam int CFG_WIDTH       = 32;
    localparam int TBL_PAD_WIDTH   = CFG_WIDTH - 1 - SLICE_IDX_WIDTH - CHUNK_IDX_WIDTH
                                     - CHUNK_WIDTH - COEF_WIDTH;
    localparam int NOISE_PAD_WIDTH = CFG_WIDTH - 1 - NOISE_LVL_WIDTH;

    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1

    // one seed per lane so the lanes see uncorrelated noise
    localparam logic [31:0] NOISE_SEEDS [NUM_SLICES] = '{
        32'h3a91_c05e, 32'h7d24_18b3, 32'hc6e0_5f71, 32'h0b5d_a29c,
        32'he413_7cd8, 32'h59af_0e46, 32'h92c7_b315, 32'h1f68_d4ea
    };

    typedef struct packed {
        logic                 sgn;                       // set when the sample is negative
        logic [ADC_WIDTH-1:0] mag;
    } slice_out_t;

    typedef struct packed {
        logic                       we;
        logic [SLICE_IDX_WIDTH-1:0] slice;
        logic [CHUNK_IDX_WIDTH-1:0] chunk_idx;
        logic [CHUNK_WIDTH-1:0]     chunk_val;
        logic [COEF_WIDTH-1:0]      coef;
    } table_wr_t;

    typedef struct packed {
        logic                       kind;                // 0 for a table write
        logic [SLICE_IDX_WIDTH-1:0] slice;
        logic [CHUNK_IDX_WIDTH-1:0] chunk_idx;
        logic [CHUNK_WIDTH-1:0]     chunk_val;
        logic [COEF_WIDTH-1:0]      coef;
        logic [TBL_PAD_WIDTH-1:0]   rsvd;
    } cfg_table_t;

    typedef struct packed {
        logic                       kind;                // 1 for a noise setting
        logic [NOISE_LVL_WIDTH-1:0] noise_level;
        logic [NOISE_PAD_WIDTH-1:0] rsvd;
    } cfg_noise_t;

    typedef union packed {
        cfg_table_t tbl;
        cfg_noise_t noise;
    } cfg_word_u;

endpackage

/* cfg_port.sv */
`timescale 1ns/1ps

module cfg_port (
    input  logic                                     emu_clk,
    input  logic                                     emu_rst,
    input  logic                                     cfg_req_i,
    input  chan_emu_pkg::cfg_word_u                  cfg_word_i,
    output logic                                     cfg_ack_o,
    output chan_emu_pkg::table_wr_t                  table_wr_o,
    output logic [chan_emu_pkg::NOISE_LVL_WIDTH-1:0] noise_level_o
);

    logic                                     ack_q;
    logic                                     accept;
    chan_emu_pkg::table_wr_t                  wr_q;
    logic [chan_emu_pkg::NOISE_LVL_WIDTH-1:0] level_q;

    // a request is taken once, on the cycle before ack goes high
    assign accept = cfg_req_i && !ack_q;

    always_ff @(posedge emu_clk) begin
        if (accept) begin
            wr_q.slice     <= cfg_word_i.tbl.slice;
            wr_q.chunk_idx <= cfg_word_i.tbl.chunk_idx;
            wr_q.chunk_val <= cfg_word_i.tbl.chunk_val;
            wr_q.coef      <= cfg_word_i.tbl.coef;
        end
        if (emu_rst) begin
            ack_q   <= 1'b0;
            wr_q.we <= 1'b0;
            level_q <= '0;                               // no noise
        end else begin
            ack_q   <= cfg_req_i;                        // follows req by one cycle
            wr_q.we <= accept && !cfg_word_i.tbl.kind;   // single-cycle strobe
            if (accept && cfg_word_i.noise.kind) begin
                level_q <= cfg_word_i.noise.noise_level;
            end
        end
    end

    assign cfg_ack_o     = ack_q;
    assign table_wr_o    = wr_q;   // broadcast to all slices
    assign noise_level_o = level_q;

endmodule

/* chunk_sequencer.sv */
`timescale 1ns/1ps

module chunk_sequencer (
    input  logic                                     emu_clk,
    input  logic                                     emu_rst,
    output logic [chan_emu_pkg::CHUNK_IDX_WIDTH-1:0] chunk_idx_o,
    output logic                                     acc_load_o,
    output logic                                     last_cycle_o,
    output logic                                     clk_adc_o
);

    logic [chan_emu_pkg::CNT_WIDTH-1:0] count_q;
    logic [chan_emu_pkg::CNT_WIDTH-1:0] count_d;
    logic                               clk_low_next;
    logic                               clk_adc_q;

    assign count_d = (int'(count_q) == chan_emu_pkg::FRAME_CYCLES - 1) ? '0 : count_q + 1'b1;

    // decoded from the next count so the clock comes straight from a flop
    assign clk_low_next = (int'(count_d) >= chan_emu_pkg::CLK_FALL) &&
                          (int'(count_d) <= chan_emu_pkg::CLK_RISE);

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            count_q   <= '0;
            clk_adc_q <= 1'b1;        // count 0 is in the high half
        end else begin
            count_q   <= count_d;
            clk_adc_q <= !clk_low_next;
        end
    end

    // chunk index only walks during the first NUM_CHUNKS counts
    assign chunk_idx_o = (int'(count_q) < chan_emu_pkg::NUM_CHUNKS) ?
                         count_q[chan_emu_pkg::CHUNK_IDX_WIDTH-1:0] : '0;

    assign acc_load_o   = (int'(count_q) == 1);   // first table read lands here
    assign last_cycle_o = (int'(count_q) == chan_emu_pkg::FRAME_CYCLES - 1);
    assign clk_adc_o    = clk_adc_q;

endmodule

/* bit_history.sv */
`timescale 1ns/1ps

module bit_history (
    input  logic                                     emu_clk,
    input  logic                                     emu_rst,
    input  logic [chan_emu_pkg::NUM_SLICES-1:0]      rx_bits_i,
    input  logic                                     shift_i,
    input  logic [chan_emu_pkg::CHUNK_IDX_WIDTH-1:0] chunk_idx_i,
    output logic [chan_emu_pkg::WINDOW_WIDTH-1:0]    window_o
);

    // newest bit sits at the top, oldest falls off the bottom
    logic [chan_emu_pkg::HIST_WIDTH-1:0] hist_q;

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            hist_q <= '0;
        end else if (shift_i) begin
            hist_q <= {rx_bits_i, hist_q[chan_emu_pkg::HIST_WIDTH-1:chan_emu_pkg::NUM_SLICES]};
        end
    end

    // window bit j is the bit j places older than the start of the chunk,
    // so slice s reads its value LSB-first from window bits s and up
    always_comb begin
        for (int j = 0; j < chan_emu_pkg::WINDOW_WIDTH; j++) begin
            window_o[j] = hist_q[chan_emu_pkg::HIST_WIDTH - 1
                                 - chan_emu_pkg::CHUNK_WIDTH * int'(chunk_idx_i) - j];
        end
    end

endmodule

/* noise_lfsr.sv */
`timescale 1ns/1ps

module noise_lfsr #(
    parameter logic [31:0] SEED = 32'h0000_0001
) (
    input  logic                                     emu_clk,
    input  logic                                     emu_rst,
    input  logic                                     step_i,
    input  logic [chan_emu_pkg::NOISE_LVL_WIDTH-1:0] noise_level_i,
    output logic signed [chan_emu_pkg::NOISE_WIDTH-1:0] noise_o
);

    logic [31:0]                               lfsr_q;
    logic signed [chan_emu_pkg::NOISE_WIDTH-1:0] raw;

    // Galois form, shifting right
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            lfsr_q <= SEED;
        end else if (step_i) begin
            lfsr_q <= {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? chan_emu_pkg::LFSR_TAPS : '0);
        end
    end

    assign raw = lfsr_q[chan_emu_pkg::NOISE_WIDTH-1:0];

    always_comb begin
        if (noise_level_i == '0) begin
            noise_o = '0;
        end else if (int'(noise_level_i) >= chan_emu_pkg::NOISE_WIDTH) begin
            noise_o = raw;             // full scale, levels above 8 clamp here
        end else begin
            noise_o = raw >>> (chan_emu_pkg::NOISE_WIDTH - int'(noise_level_i));
        end
    end

endmodule

/* analog_slice.sv */
`timescale 1ns/1ps

module analog_slice #(
    parameter int SLICE_IDX = 0
) (
    input  logic                                     emu_clk,
    input  logic                                     emu_rst,
    input  logic [chan_emu_pkg::WINDOW_WIDTH-1:0]    window_i,
    input  logic [chan_emu_pkg::CHUNK_IDX_WIDTH-1:0] chunk_idx_i,
    input  logic                                     acc_load_i,
    input  logic                                     last_cycle_i,
    input  chan_emu_pkg::table_wr_t                  table_wr_i,
    input  logic [chan_emu_pkg::NOISE_LVL_WIDTH-1:0] noise_level_i,
    output chan_emu_pkg::slice_out_t                 out_o
);

    // step response contribution per chunk position and chunk value
    logic signed [chan_emu_pkg::COEF_WIDTH-1:0]
        coef_mem [chan_emu_pkg::NUM_CHUNKS][chan_emu_pkg::TABLE_DEPTH];

    logic signed [chan_emu_pkg::COEF_WIDTH-1:0]  coef_q;
    logic [chan_emu_pkg::CHUNK_WIDTH-1:0]        chunk_val;
    logic signed [chan_emu_pkg::NOISE_WIDTH-1:0] noise;
    logic signed [chan_emu_pkg::ACC_WIDTH-1:0]   coef_ext;
    logic signed [chan_emu_pkg::ACC_WIDTH-1:0]   noise_ext;
    logic signed [chan_emu_pkg::ACC_WIDTH-1:0]   acc_q;
    logic signed [chan_emu_pkg::ACC_WIDTH-1:0]   total;
    logic signed [chan_emu_pkg::ACC_WIDTH-1:0]   total_abs;
    chan_emu_pkg::slice_out_t                    out_q;

    noise_lfsr #(
        .SEED(chan_emu_pkg::NOISE_SEEDS[SLICE_IDX])
    ) i_noise_lfsr (
        .emu_clk       (emu_clk),
        .emu_rst       (emu_rst),
        .step_i        (last_cycle_i),    // one new draw per frame
        .noise_level_i (noise_level_i),
        .noise_o       (noise)
    );

    assign chunk_val = window_i[SLICE_IDX +: chan_emu_pkg::CHUNK_WIDTH];

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            for (int k = 0; k < chan_emu_pkg::NUM_CHUNKS; k++) begin
                for (int v = 0; v < chan_emu_pkg::TABLE_DEPTH; v++) begin
                    coef_mem[k][v] <= '0;
                end
            end
        end else if (table_wr_i.we && int'(table_wr_i.slice) == SLICE_IDX) begin
            coef_mem[table_wr_i.chunk_idx][table_wr_i.chunk_val] <= table_wr_i.coef;
        end
    end

    always_ff @(posedge emu_clk) begin
        coef_q <= coef_mem[chunk_idx_i][chunk_val];   // lags chunk_idx by one cycle
    end

    assign coef_ext = {{(chan_emu_pkg::ACC_WIDTH - chan_emu_pkg::COEF_WIDTH)
                        {coef_q[chan_emu_pkg::COEF_WIDTH-1]}}, coef_q};
    assign noise_ext = {{(chan_emu_pkg::ACC_WIDTH - chan_emu_pkg::NOISE_WIDTH)
                         {noise[chan_emu_pkg::NOISE_WIDTH-1]}}, noise};

    // counts 2..4 add onto the chunk 0 term, count 0 is overwritten later
    always_ff @(posedge emu_clk) begin
        if (acc_load_i) begin
            acc_q <= coef_ext;
        end else begin
            acc_q <= acc_q + coef_ext;
        end
    end

    assign total     = acc_q + noise_ext;
    assign total_abs = total[chan_emu_pkg::ACC_WIDTH-1] ? -total : total;

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            out_q <= '0;
        end else if (last_cycle_i) begin
            out_q.sgn <= total[chan_emu_pkg::ACC_WIDTH-1];
            out_q.mag <= (|total_abs[chan_emu_pkg::ACC_WIDTH-1:chan_emu_pkg::ADC_WIDTH]) ?
                         '1 : total_abs[chan_emu_pkg::ADC_WIDTH-1:0];   // clip at full scale
        end
    end

    assign out_o = out_q;

endmodule

/* chan_emu_top.sv */
`timescale 1ns/1ps

module chan_emu_top (
    input  logic                                  emu_clk,
    input  logic                                  emu_rst,
    input  logic [chan_emu_pkg::NUM_SLICES-1:0]   rx_bits_i,     // bit 0 oldest
    input  logic                                  cfg_req_i,
    input  chan_emu_pkg::cfg_word_u               cfg_word_i,
    output logic                                  cfg_ack_o,
    output logic                                  frame_o,
    output logic                                  clk_adc_o,
    output chan_emu_pkg::slice_out_t [chan_emu_pkg::NUM_SLICES-1:0] slice_out_o
);

    chan_emu_pkg::table_wr_t                  table_wr;
    logic [chan_emu_pkg::NOISE_LVL_WIDTH-1:0] noise_level;
    logic [chan_emu_pkg::CHUNK_IDX_WIDTH-1:0] chunk_idx;
    logic                                     acc_load;
    logic                                     last_cycle;
    logic [chan_emu_pkg::WINDOW_WIDTH-1:0]    window;

    cfg_port i_cfg_port (
        .emu_clk       (emu_clk),
        .emu_rst       (emu_rst),
        .cfg_req_i     (cfg_req_i),
        .cfg_word_i    (cfg_word_i),
        .cfg_ack_o     (cfg_ack_o),
        .table_wr_o    (table_wr),
        .noise_level_o (noise_level)
    );

    chunk_sequencer i_chunk_sequencer (
        .emu_clk      (emu_clk),
        .emu_rst      (emu_rst),
        .chunk_idx_o  (chunk_idx),
        .acc_load_o   (acc_load),
        .last_cycle_o (last_cycle),
        .clk_adc_o    (clk_adc_o)
    );

    // new frame bits enter at the end of each frame
    bit_history i_bit_history (
        .emu_clk     (emu_clk),
        .emu_rst     (emu_rst),
        .rx_bits_i   (rx_bits_i),
        .shift_i     (last_cycle),
        .chunk_idx_i (chunk_idx),
        .window_o    (window)
    );

    assign frame_o = last_cycle;   // tb presents the next frame on this

    // one slice per interleaved lane, all sharing the same window
    for (genvar g = 0; g < chan_emu_pkg::NUM_SLICES; g++) begin : g_slice
        analog_slice #(
            .SLICE_IDX(g)
        ) i_analog_slice (
            .emu_clk       (emu_clk),
            .emu_rst       (emu_rst),
            .window_i      (window),
            .chunk_idx_i   (chunk_idx),
            .acc_load_i    (acc_load),
            .last_cycle_i  (last_cycle),
            .table_wr_i    (table_wr),
            .noise_level_i (noise_level),
            .out_o         (slice_out_o[g])
        );
    end

endmodule

/* chan_emu_checker.sv */
`timescale 1ns/1ps

module chan_emu_checker (
    input  logic                                                    emu_clk,
    input  logic                                                    emu_rst,
    input  logic                                                    cfg_req_i,
    input  logic                                                    cfg_ack_i,
    input  logic                                                    frame_i,
    input  logic                                                    clk_adc_i,
    input  chan_emu_pkg::slice_out_t [chan_emu_pkg::NUM_SLICES-1:0] slice_out_i
);

    logic [chan_emu_pkg::CNT_WIDTH-1:0] phase_q;   // cycles since the start of a frame

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            phase_q <= '0;
        end else if (int'(phase_q) == chan_emu_pkg::FRAME_CYCLES - 1) begin
            phase_q <= '0;
        end else begin
            phase_q <= phase_q + 1'b1;
        end
    end

    // four-phase ordering
    a_ack_rise: assert property (@(posedge emu_clk) disable iff (emu_rst)
        $rose(cfg_ack_i) |-> $past(cfg_req_i))
        else $error("cfg_ack_o rose without a pending request");
    a_ack_fall: assert property (@(posedge emu_clk) disable iff (emu_rst)
        $fell(cfg_ack_i) |-> !$past(cfg_req_i))
        else $error("cfg_ack_o fell while the request was still high");
    a_req_rise: assert property (@(posedge emu_clk) disable iff (emu_rst)
        $rose(cfg_req_i) |-> !cfg_ack_i)
        else $error("new request raised before cfg_ack_o was low");

    a_reset: assert property (@(posedge emu_clk)
        emu_rst |=> (!cfg_ack_i && slice_out_i == '0))
        else $error("outputs not cleared by reset");

    a_frame: assert property (@(posedge emu_clk) disable iff (emu_rst)
        frame_i == (int'(phase_q) == chan_emu_pkg::FRAME_CYCLES - 1))
        else $error("frame_o not high exactly once per frame");

    // low for three samples, then high for three
    a_clk_low: assert property (@(posedge emu_clk) disable iff (emu_rst)
        $rose(clk_adc_i) |-> (!$past(clk_adc_i, 1) && !$past(clk_adc_i, 2) &&
                              !$past(clk_adc_i, 3) && $past(clk_adc_i, 4)))
        else $error("clk_adc_o low phase is not three cycles");
    a_clk_high: assert property (@(posedge emu_clk) disable iff (emu_rst)
        $fell(clk_adc_i) |-> ($past(clk_adc_i, 2) && $past(clk_adc_i, 3) &&
                              ($past(emu_rst, 4) || !$past(clk_adc_i, 4))))
        else $error("clk_adc_o high phase is not three cycles");

endmodule

/* chan_emu_tb.sv */
`timescale 1ns/1ps

module chan_emu_tb;

    localparam int NUM_CFG_WRITES = chan_emu_pkg::NUM_SLICES * chan_emu_pkg::TABLE_DEPTH
                                    * (chan_emu_pkg::NUM_CHUNKS + 1) + 1;
    localparam int NUM_FRAMES     = 2 + 3 * 5 + 40 + 20 + 20;
    localparam int TIMEOUT_CYCLES = NUM_CFG_WRITES * 10
                                    + NUM_FRAMES * chan_emu_pkg::FRAME_CYCLES + 100;
    localparam int NOISE_LEVEL    = 3;
    localparam int NOISE_TOL      = (1 << NOISE_LEVEL) / 2;
    localparam int CHK_NONE       = 0;
    localparam int CHK_EXACT      = 1;
    localparam int CHK_NOISE      = 2;
    localparam int CHK_SAT        = 3;

    logic                                  emu_clk;
    logic                                  emu_rst;
    logic [chan_emu_pkg::NUM_SLICES-1:0]   rx_bits;
    logic                                  cfg_req;
    chan_emu_pkg::cfg_word_u               cfg_word;
    logic                                  cfg_ack;
    logic                                  frame;
    logic                                  clk_adc;
    chan_emu_pkg::slice_out_t [chan_emu_pkg::NUM_SLICES-1:0] slice_out;

    // reference copies of the tables and of the bit history, age_m[0] newest
    int tbl_m [chan_emu_pkg::NUM_SLICES][chan_emu_pkg::NUM_CHUNKS][chan_emu_pkg::TABLE_DEPTH];
    bit age_m [chan_emu_pkg::HIST_WIDTH];
    int err_count;
    int check_count;
    int noise_seen;   // noisy samples that moved off the noise-free value

    chan_emu_top i_chan_emu_top (
        .emu_clk     (emu_clk),
        .emu_rst     (emu_rst),
        .rx_bits_i   (rx_bits),
        .cfg_req_i   (cfg_req),
        .cfg_word_i  (cfg_word),
        .cfg_ack_o   (cfg_ack),
        .frame_o     (frame),
        .clk_adc_o   (clk_adc),
        .slice_out_o (slice_out)
    );

    bind chan_emu_top chan_emu_checker i_chan_emu_checker (
        .emu_clk     (emu_clk),
        .emu_rst     (emu_rst),
        .cfg_req_i   (cfg_req_i),
        .cfg_ack_i   (cfg_ack_o),
        .frame_i     (frame_o),
        .clk_adc_i   (clk_adc_o),
        .slice_out_i (slice_out_o)
    );

    initial begin
        emu_clk = 1'b0;
        forever #10 emu_clk = ~emu_clk;   // 20 ns period
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge emu_clk);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    function automatic int model_sum(input int s);
        int sum;
        int val;
        sum = 0;
        for (int k = 0; k < chan_emu_pkg::NUM_CHUNKS; k++) begin
            val = 0;
            for (int j = 0; j < chan_emu_pkg::CHUNK_WIDTH; j++) begin
                val = val | (int'(age_m[chan_emu_pkg::CHUNK_WIDTH * k + s + j]) << j);
            end
            sum = sum + tbl_m[s][k][val];
        end
        return sum;
    endfunction

    function automatic chan_emu_pkg::slice_out_t sign_mag(input int value);
        chan_emu_pkg::slice_out_t res;
        int mag;
        mag = (value < 0) ? -value : value;
        res.sgn = (value < 0);
        res.mag = (mag > (1 << chan_emu_pkg::ADC_WIDTH) - 1) ?
                  '1 : mag[chan_emu_pkg::ADC_WIDTH-1:0];
        return res;
    endfunction

    function automatic logic [chan_emu_pkg::NUM_SLICES-1:0] rand_bits();
        logic [31:0] r;
        r = $urandom;
        return r[chan_emu_pkg::NUM_SLICES-1:0];
    endfunction

    task automatic cfg_write(input chan_emu_pkg::cfg_word_u word);
        @(negedge emu_clk);
        cfg_word = word;
        cfg_req  = 1'b1;
        @(negedge emu_clk);
        while (!cfg_ack) @(negedge emu_clk);
        cfg_req = 1'b0;
        @(negedge emu_clk);
        while (cfg_ack) @(negedge emu_clk);   // ack low before the next request
    endtask

    task automatic table_write(input int s, input int k, input int v, input int c);
        chan_emu_pkg::cfg_word_u word;
        word               = '0;
        word.tbl.kind      = 1'b0;
        word.tbl.slice     = s[chan_emu_pkg::SLICE_IDX_WIDTH-1:0];
        word.tbl.chunk_idx = k[chan_emu_pkg::CHUNK_IDX_WIDTH-1:0];
        word.tbl.chunk_val = v[chan_emu_pkg::CHUNK_WIDTH-1:0];
        word.tbl.coef      = c[chan_emu_pkg::COEF_WIDTH-1:0];
        cfg_write(word);
        tbl_m[s][k][v] = c;
    endtask

    task automatic noise_write(input int level);
        chan_emu_pkg::cfg_word_u word;
        word                   = '0;
        word.noise.kind        = 1'b1;
        word.noise.noise_level = level[chan_emu_pkg::NOISE_LVL_WIDTH-1:0];
        cfg_write(word);
    endtask

    task automatic compare_slice(input int s, input chan_emu_pkg::slice_out_t exp_o,
                                 input int exp_sum, input int mode);
        chan_emu_pkg::slice_out_t got;
        int diff;
        got = slice_out[s];
        diff = (got.sgn ? -int'(got.mag) : int'(got.mag)) - exp_sum;
        check_count++;
        if (mode == CHK_NOISE) begin
            assert (diff >= -NOISE_TOL && diff <= NOISE_TOL) else begin
                err_count++;
                $display("ERR slice_out_o[%0d]: expected %h +/- %0d, got %h", s, exp_o,
                         NOISE_TOL, got);
            end
            if (diff != 0) begin
                noise_seen++;
            end
        end else begin
            assert (got == exp_o) else begin
                err_count++;
                $display("ERR slice_out_o[%0d]: expected %h, got %h", s, exp_o, got);
            end
            if (mode == CHK_SAT) begin
                assert (got.mag == '1) else begin
                    err_count++;
                    $display("ERR slice_out_o[%0d].mag: expected ff, got %h", s, got.mag);
                end
            end
        end
    endtask

    // result registered at this frame edge comes from the history before the shift
    task automatic send_frame(input logic [chan_emu_pkg::NUM_SLICES-1:0] bits, input int mode);
        chan_emu_pkg::slice_out_t exp_o [chan_emu_pkg::NUM_SLICES];
        int exp_sum [chan_emu_pkg::NUM_SLICES];
        @(negedge emu_clk);
        while (!frame) @(negedge emu_clk);
        for (int s = 0; s < chan_emu_pkg::NUM_SLICES; s++) begin
            exp_sum[s] = model_sum(s);
            exp_o[s]   = sign_mag(exp_sum[s]);
        end
        rx_bits = bits;
        for (int i = chan_emu_pkg::HIST_WIDTH - 1; i >= chan_emu_pkg::NUM_SLICES; i--) begin
            age_m[i] = age_m[i - chan_emu_pkg::NUM_SLICES];
        end
        for (int i = 0; i < chan_emu_pkg::NUM_SLICES; i++) begin
            age_m[i] = bits[chan_emu_pkg::NUM_SLICES - 1 - i];   // msb is the newest bit
        end
        @(negedge emu_clk);
        if (mode != CHK_NONE) begin
            for (int s = 0; s < chan_emu_pkg::NUM_SLICES; s++) begin
                compare_slice(s, exp_o[s], exp_sum[s], mode);
            end
        end
    endtask

    task automatic check_reset_state();
        check_count++;
        assert (!cfg_ack && slice_out == '0 && clk_adc) else begin
            err_count++;
            $display("ERR reset state: cfg_ack_o %h, clk_adc_o %h, slice_out_o %h",
                     cfg_ack, clk_adc, slice_out);
        end
    endtask

    task automatic check_noise_seen();
        check_count++;
        assert (noise_seen > 0) else begin
            err_count++;
            $display("noise level %0d was set but no output moved off the noise-free value",
                     NOISE_LEVEL);
        end
    endtask

    task automatic load_random_tables();
        for (int s = 0; s < chan_emu_pkg::NUM_SLICES; s++) begin
            for (int k = 0; k < chan_emu_pkg::NUM_CHUNKS; k++) begin
                for (int v = 0; v < chan_emu_pkg::TABLE_DEPTH; v++) begin
                    table_write(s, k, v, int'($urandom % 121) - 60);   // sum stays unclipped
                end
            end
        end
    endtask

    task automatic load_saturating_tables();
        int c;
        for (int s = 0; s < chan_emu_pkg::NUM_SLICES; s++) begin
            for (int v = 0; v < chan_emu_pkg::TABLE_DEPTH; v++) begin
                c = 1000 + int'($urandom % 20000);
                if ($urandom % 2 == 1) begin
                    c = -c;
                end
                table_write(s, 0, v, c);
            end
        end
    endtask

    initial begin
        rx_bits     = '0;
        cfg_req     = 1'b0;
        cfg_word    = '0;
        emu_rst     = 1'b1;
        err_count   = 0;
        check_count = 0;
        noise_seen  = 0;
        void'($urandom(32'hf8234aa4));
        tbl_m = '{default: '{default: '{default: 0}}};
        age_m = '{default: 1'b0};

        repeat (3) begin
            @(negedge emu_clk);
            check_reset_state();
        end
        emu_rst = 1'b0;
        repeat (2) send_frame(rand_bits(), CHK_EXACT);   // empty tables give zero

        load_random_tables();
        repeat (5) send_frame('0, CHK_NONE);   // settle history and tables
        repeat (40) send_frame(rand_bits(), CHK_EXACT);

        noise_write(NOISE_LEVEL);
        repeat (5) send_frame('0, CHK_NONE);
        repeat (20) send_frame(rand_bits(), CHK_NOISE);
        check_noise_seen();

        load_saturating_tables();
        repeat (5) send_frame('0, CHK_NONE);
        repeat (20) send_frame(rand_bits(), CHK_SAT);

        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* compile.f */
chan_emu_pkg.sv
cfg_port.sv
chunk_sequencer.sv
bit_history.sv
noise_lfsr.sv
analog_slice.sv
chan_emu_top.sv
chan_emu_checker.sv
chan_emu_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds and runs the chan_emu testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module chan_emu_tb \
    -f compile.f -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/Vchan_emu_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF "*** TEST FAILED ***" "$LOG"; then
    exit 1
fi
exit 0
